// ==== filelist.f ====
+incdir+include
hdl/trig_csr_pkg.sv
hdl/trig_core_pkg.sv
hdl/trig_csr_bank.sv
hdl/trig_exec_match.sv
hdl/trig_lsu_match.sv
hdl/trig_hit_merge.sv
hdl/debug_triggers.sv
sim/trig_checker.sv
sim/tb_debug_triggers.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the debug trigger testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_debug_triggers

verilator --binary --timing --assert -f filelist.f --top-module "$TOP" \
  -Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
exit 0

// ==== sim/tb_debug_triggers.sv ====
//////////////////////////////////////////////////
// Testbench for the debug trigger unit with APB setup and IF/EX stimulus
// Responses are compared by trig_checker
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "trig_consts.svh"

module tb_debug_triggers;
  import trig_csr_pkg::*;
  import trig_core_pkg::*;

  localparam int NUM_TESTS  = 5;
  localparam int TIMEOUT_NS = NUM_TESTS * 200 * 40;  // 200 cycles per test

  logic      clk = 1'b0;
  logic      rst_n;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;
  if_req_t   if_req;
  lsu_req_t  lsu_req;
  logic      debug_mode;
  logic      debug_entry;
  trig_vec_t match_if;
  trig_vec_t match_ex;
  logic      debug_req;
  int        chk_errs;              // From the checker
  int        tb_errs;               // From direct read checks
  int        errs_at_start;
  int        tests_pass;
  int        tests_fail;
  csr_data_t rd;
  logic      rd_err;
  csr_data_t t2;

  always #20 clk = ~clk;  // 40 ns period

  debug_triggers u_debug_triggers (
    .clk             (clk),
    .rst_n_i         (rst_n),
    .apb_req_i       (apb_req),
    .if_req_i        (if_req),
    .lsu_req_i       (lsu_req),
    .debug_mode_i    (debug_mode),
    .debug_entry_i   (debug_entry),
    .apb_rsp_o       (apb_rsp),
    .trig_match_if_o (match_if),
    .trig_match_ex_o (match_ex),
    .debug_req_o     (debug_req)
  );

  trig_checker u_trig_checker (
    .clk             (clk),
    .rst_n_i         (rst_n),
    .apb_req_i       (apb_req),
    .apb_rsp_i       (apb_rsp),
    .if_req_i        (if_req),
    .lsu_req_i       (lsu_req),
    .debug_mode_i    (debug_mode),
    .debug_entry_i   (debug_entry),
    .trig_match_if_i (match_if),
    .trig_match_ex_i (match_ex),
    .debug_req_i     (debug_req),
    .err_cnt_o       (chk_errs)
  );

  task automatic next_cycle();
    @(posedge clk);
    #1;  // Drive just after the edge
  endtask

  task automatic apb_write(input apb_addr_t addr, input csr_data_t data);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    next_cycle();
    apb_req.penable = 1'b1;  // Access phase ends at the next edge
    next_cycle();
    apb_req = '0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output csr_data_t data, output logic err);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
    next_cycle();
    apb_req.penable = 1'b1;
    @(negedge clk);          // prdata valid mid access
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    next_cycle();
    apb_req = '0;
  endtask

  task automatic check_read(input string sig, input apb_addr_t addr, input csr_data_t exp);
    apb_read(addr, rd, rd_err);
    if (rd_err || (rd !== exp)) begin
      $display("ERROR t=%0t %s expected %h got %h (pslverr %b)", $time, sig, exp, rd, rd_err);
      tb_errs++;
    end
  endtask

  task automatic cfg_trigger(input int idx, input csr_data_t t1, input csr_data_t t2v);
    apb_write(`TRIG_ADDR_TSELECT, csr_data_t'(idx));
    apb_write(`TRIG_ADDR_TDATA1, t1);
    apb_write(`TRIG_ADDR_TDATA2, t2v);
  endtask

  // mcontrol6 write word with esl as the execute, store and load bits
  function automatic csr_data_t mc6(input logic [3:0] mode, input logic m, input logic u,
                                    input logic [2:0] esl);
    return {4'd6, 17'd0, mode, m, 2'b00, u, esl};
  endfunction

  // Random requests with half of them close to base
  task automatic run_reqs(input logic is_lsu, input int n, input csr_data_t base);
    csr_data_t a;
    for (int k = 0; k < n; k++) begin
      a = ($urandom_range(0, 1) == 1) ?
          (base & ~32'd3) + 32'($urandom_range(0, 4) * 4) - 32'd8 : $urandom;
      if (is_lsu) begin
        lsu_req.valid = 1'b1;
        lsu_req.addr  = a;
        lsu_req.we    = 1'($urandom_range(0, 1));
        lsu_req.be    = 4'($urandom_range(1, 15));
        lsu_req.priv  = ($urandom_range(0, 1) == 1) ? PRIV_LVL_M : PRIV_LVL_U;
      end else begin
        if_req.valid = 1'b1;
        if_req.pc    = a + 32'($urandom_range(0, 3));
        if_req.priv  = ($urandom_range(0, 1) == 1) ? PRIV_LVL_M : PRIV_LVL_U;
      end
      debug_mode = ($urandom_range(0, 7) == 0);
      next_cycle();
    end
    if_req     = '0;
    lsu_req    = '0;
    debug_mode = 1'b0;
  endtask

  task automatic mode_pass(input logic is_lsu, input logic [3:0] mode);
    t2 = $urandom;
    if (is_lsu) begin
      cfg_trigger(0, mc6(mode, 1'b1, 1'b1, 3'b011), t2);          // Load and store
      cfg_trigger(1, mc6(mode, 1'b1, 1'b0, 3'b010), t2 + 32'd5);  // Store in M only
    end else begin
      cfg_trigger(0, mc6(mode, 1'b1, 1'b0, 3'b100), t2);
      cfg_trigger(1, mc6(mode, 1'b0, 1'b1, 3'b100), t2 + 32'd2);
    end
    run_reqs(is_lsu, 32, t2);
  endtask

  task automatic finish_test(input int num, input string name);
    int errs;
    next_cycle();
    next_cycle();  // Last responses reach the checker
    errs = chk_errs + tb_errs - errs_at_start;
    if (errs == 0) begin
      tests_pass++;
      $display("Test %0d %s: PASS", num, name);
    end else begin
      tests_fail++;
      $display("Test %0d %s: FAIL with %0d errors", num, name, errs);
    end
    errs_at_start = chk_errs + tb_errs;
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog: run did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h96e882bf));
    rst_n = 1'b0;
    apb_req = '0;
    if_req = '0;
    lsu_req = '0;
    debug_mode = 1'b0;
    debug_entry = 1'b0;
    tb_errs = 0;
    errs_at_start = 0;
    tests_pass = 0;
    tests_fail = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    //////////////////////////////////////////////////
    // 1 Reset values and map
    check_read("tselect", `TRIG_ADDR_TSELECT, 32'd0);
    check_read("tdata1", `TRIG_ADDR_TDATA1, `TDATA1_RST_VAL);
    check_read("tinfo", `TRIG_ADDR_TINFO, `TINFO_VAL);
    apb_read(4'h2, rd, rd_err);
    if (!rd_err) begin
      $display("Read of unmapped offset 0x2 at t=%0t gave no slave error", $time);
      tb_errs++;
    end
    apb_write(`TRIG_ADDR_TSELECT, 32'd1);
    apb_write(`TRIG_ADDR_TSELECT, 32'd2);  // Out of range
    check_read("tselect", `TRIG_ADDR_TSELECT, 32'd1);
    apb_write(`TRIG_ADDR_TSELECT, 32'd0);
    finish_test(1, "reset and registers");

    // 2 WARL resolution
    apb_write(`TRIG_ADDR_TDATA1, mc6(4'd5, 1'b1, 1'b0, 3'b111));
    check_read("tdata1", `TRIG_ADDR_TDATA1, 32'h6800_1047);
    apb_write(`TRIG_ADDR_TDATA1, 32'h3000_0047);
    check_read("tdata1", `TRIG_ADDR_TDATA1, `TDATA1_RST_VAL);
    for (int i = 0; i < `DBG_NUM_TRIGGERS; i++) begin
      t2 = $urandom;
      apb_write(`TRIG_ADDR_TSELECT, csr_data_t'(i));
      apb_write(`TRIG_ADDR_TDATA2, t2);
      check_read("tdata2", `TRIG_ADDR_TDATA2, t2);
    end
    finish_test(2, "tdata1 WARL");

    // 3 and 4 address match in all modes
    mode_pass(1'b0, MATCH_EQ);
    mode_pass(1'b0, MATCH_GE);
    mode_pass(1'b0, MATCH_LT);
    finish_test(3, "instruction address match");
    mode_pass(1'b1, MATCH_EQ);
    mode_pass(1'b1, MATCH_GE);
    mode_pass(1'b1, MATCH_LT);
    finish_test(4, "load/store match");

    //////////////////////////////////////////////////
    // 5 hit0 after flushing hits left from earlier tests
    debug_entry = 1'b1;
    next_cycle();
    debug_entry = 1'b0;
    next_cycle();
    cfg_trigger(0, mc6(MATCH_EQ, 1'b1, 1'b0, 3'b100), 32'h0000_0100);
    cfg_trigger(1, mc6(MATCH_EQ, 1'b1, 1'b0, 3'b100), 32'h0000_0100);
    if_req = '{valid: 1'b1, pc: 32'h0000_0100, priv: PRIV_LVL_M};  // Both triggers hit
    next_cycle();
    if_req = '0;
    next_cycle();
    apb_write(`TRIG_ADDR_TDATA1, 32'h0);  // Trigger 1 disabled with its hit pending
    debug_entry = 1'b1;
    next_cycle();
    debug_entry = 1'b0;
    next_cycle();
    next_cycle();
    apb_write(`TRIG_ADDR_TSELECT, 32'd0);
    check_read("tdata1[0]", `TRIG_ADDR_TDATA1, 32'h6840_1044);
    apb_write(`TRIG_ADDR_TSELECT, 32'd1);
    check_read("tdata1[1]", `TRIG_ADDR_TDATA1, `TDATA1_RST_VAL);
    finish_test(5, "hit0 update");

    $display("Tests passed %0d, tests failed %0d", tests_pass, tests_fail);
    if (tests_fail == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sim/trig_checker.sv ====
//////////////////////////////////////////////////
// Shadow register model, reference match and per-cycle compare of the DUT
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "trig_consts.svh"

module trig_checker (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  trig_csr_pkg::apb_req_t   apb_req_i,
  input  trig_csr_pkg::apb_rsp_t   apb_rsp_i,
  input  trig_core_pkg::if_req_t   if_req_i,
  input  trig_core_pkg::lsu_req_t  lsu_req_i,
  input  logic                     debug_mode_i,
  input  logic                     debug_entry_i,
  input  trig_core_pkg::trig_vec_t trig_match_if_i,
  input  trig_core_pkg::trig_vec_t trig_match_ex_i,
  input  logic                     debug_req_i,
  output int                       err_cnt_o
);
  import trig_csr_pkg::*;
  import trig_core_pkg::*;

  csr_data_t sh_tselect;
  csr_data_t sh_tdata1 [`DBG_NUM_TRIGGERS];
  csr_data_t sh_tdata2 [`DBG_NUM_TRIGGERS];
  trig_vec_t exp_if_q;   // Expected outputs in this cycle
  trig_vec_t exp_ex_q;
  trig_vec_t pend_q;     // Hits since last entry
  trig_vec_t hit_set_q;  // hit0 set at the coming edge
  int        errs = 0;

  assign err_cnt_o = errs;

  task automatic report(input string sig, input csr_data_t exp, input csr_data_t got);
    $display("ERROR t=%0t %s expected %h got %h", $time, sig, exp, got);
    errs++;
  endtask

  // Legal tdata1 after a write where only type 6 keeps its fields
  function automatic csr_data_t legal_tdata1(input csr_data_t w);
    csr_data_t res;
    if (w[31:28] == 4'd6) begin
      res = 32'h6800_1000 | (w & 32'h0040_004F);  // dmode, action 1, hit0 m u e s l
      if ((w[10:7] == 4'd2) || (w[10:7] == 4'd3)) res[10:7] = w[10:7];
    end else begin
      res = `TDATA1_RST_VAL;
    end
    return res;
  endfunction

  function automatic csr_data_t read_value(input apb_addr_t addr, output logic err);
    csr_data_t v;
    v   = '0;
    err = 1'b0;
    case (addr)
      `TRIG_ADDR_TSELECT: v = sh_tselect;
      `TRIG_ADDR_TDATA1, `TRIG_ADDR_TDATA2: begin
        for (int i = 0; i < `DBG_NUM_TRIGGERS; i++) begin
          if (sh_tselect == i) begin
            v = (addr == `TRIG_ADDR_TDATA1) ? sh_tdata1[i] : sh_tdata2[i];
          end
        end
      end
      `TRIG_ADDR_TINFO:   v = `TINFO_VAL;
      default:            err = 1'b1;
    endcase
    return v;
  endfunction

  //////////////////////////////////////////////////
  // Reference match against the shadow registers
  function automatic trig_vec_t ref_match(input logic is_lsu, input logic valid,
      input addr_t addr, input byte_en_t be, input logic we, input privlvl_e priv,
      input logic dbg);
    trig_vec_t res;
    tdata1_t   t1;
    addr_t     lo;
    addr_t     hi;
    logic      found;
    logic      en;
    logic      hit;
    res   = '0;
    lo    = addr;
    hi    = addr;
    found = 1'b0;
    if (is_lsu) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          if (!found) lo = {addr[31:2], 2'(b)};  // First enabled byte
          hi    = {addr[31:2], 2'(b)};
          found = 1'b1;
        end
      end
    end
    for (int i = 0; i < `DBG_NUM_TRIGGERS; i++) begin
      t1 = tdata1_t'(sh_tdata1[i]);
      en = valid && !dbg && (t1.ttype == TTYPE_MCONTROL6) &&
           (((priv == PRIV_LVL_M) && t1.m) || ((priv == PRIV_LVL_U) && t1.u));
      en = en && (is_lsu ? (we ? t1.store : t1.load) : t1.execute);
      case (t1.match)
        MATCH_GE: hit = (hi >= sh_tdata2[i]);
        MATCH_LT: hit = (lo < sh_tdata2[i]);
        default:  hit = is_lsu ? ((addr[31:2] == sh_tdata2[i][31:2]) && be[sh_tdata2[i][1:0]])
                               : (addr == sh_tdata2[i]);
      endcase
      res[i] = en && hit;
    end
    return res;
  endfunction

  // Inputs and outputs are both settled at the falling edge
  always @(negedge clk) begin : model_step
    trig_vec_t nxt_if;
    trig_vec_t nxt_ex;
    trig_vec_t pend_all;
    csr_data_t exp_rd;
    logic      exp_err;
    logic      acc;
    logic      wr;
    if (!rst_n_i) begin
      sh_tselect = '0;
      for (int i = 0; i < `DBG_NUM_TRIGGERS; i++) begin
        sh_tdata1[i] = `TDATA1_RST_VAL;
        sh_tdata2[i] = '0;
      end
      exp_if_q  = '0;
      exp_ex_q  = '0;
      pend_q    = '0;
      hit_set_q = '0;
    end else begin
      if (trig_match_if_i !== exp_if_q) begin
        report("trig_match_if_o", 32'(exp_if_q), 32'(trig_match_if_i));
      end
      if (trig_match_ex_i !== exp_ex_q) begin
        report("trig_match_ex_o", 32'(exp_ex_q), 32'(trig_match_ex_i));
      end
      if (debug_req_i !== |(exp_if_q | exp_ex_q)) begin
        report("debug_req_o", 32'(|(exp_if_q | exp_ex_q)), 32'(debug_req_i));
      end
      acc    = apb_req_i.psel && apb_req_i.penable;
      exp_rd = read_value(apb_req_i.paddr, exp_err);
      // pslverr only in an access to a hole and pready always high
      if (apb_rsp_i.pslverr !== (acc && exp_err)) begin
        report("pslverr", 32'(acc && exp_err), 32'(apb_rsp_i.pslverr));
      end
      if (apb_rsp_i.pready !== 1'b1) report("pready", 32'd1, 32'(apb_rsp_i.pready));
      if (acc && !apb_req_i.pwrite && (apb_rsp_i.prdata !== exp_rd)) begin
        report("prdata", exp_rd, apb_rsp_i.prdata);
      end
      // Matches use the registers as they are in this cycle
      nxt_if = ref_match(1'b0, if_req_i.valid, if_req_i.pc, 4'hF, 1'b0, if_req_i.priv,
                         debug_mode_i);
      nxt_ex = ref_match(1'b1, lsu_req_i.valid, lsu_req_i.addr, lsu_req_i.be, lsu_req_i.we,
                         lsu_req_i.priv, debug_mode_i);
      wr = acc && apb_req_i.pwrite && !exp_err;
      for (int i = 0; i < `DBG_NUM_TRIGGERS; i++) begin
        if (hit_set_q[i] && (sh_tdata1[i][31:28] == 4'd6)) begin
          sh_tdata1[i][22] = 1'b1;  // hit0 beats a write
        end else if (wr && (apb_req_i.paddr == `TRIG_ADDR_TDATA1) && (sh_tselect == i)) begin
          sh_tdata1[i] = legal_tdata1(apb_req_i.pwdata);
        end
        if (wr && (apb_req_i.paddr == `TRIG_ADDR_TDATA2) && (sh_tselect == i)) begin
          sh_tdata2[i] = apb_req_i.pwdata;
        end
      end
      if (wr && (apb_req_i.paddr == `TRIG_ADDR_TSELECT) &&
          (apb_req_i.pwdata < `DBG_NUM_TRIGGERS)) begin
        sh_tselect = apb_req_i.pwdata;
      end
      pend_all  = pend_q | exp_if_q | exp_ex_q;
      hit_set_q = debug_entry_i ? pend_all : '0;
      pend_q    = debug_entry_i ? '0 : pend_all;
      exp_if_q  = nxt_if;
      exp_ex_q  = nxt_ex;
    end
  end

endmodule

// ==== hdl/debug_triggers.sv ====
//////////////////////////////////////////////////
// Debug trigger unit top: APB register bank, IF and EX match, merge
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "trig_consts.svh"

module debug_triggers (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  trig_csr_pkg::apb_req_t   apb_req_i,
  input  trig_core_pkg::if_req_t   if_req_i,
  input  trig_core_pkg::lsu_req_t  lsu_req_i,
  input  logic                     debug_mode_i,
  input  logic                     debug_entry_i,
  output trig_csr_pkg::apb_rsp_t   apb_rsp_o,
  output trig_core_pkg::trig_vec_t trig_match_if_o,
  output trig_core_pkg::trig_vec_t trig_match_ex_o,
  output logic                     debug_req_o
);
  import trig_csr_pkg::*;
  import trig_core_pkg::*;

  tdata1_t   tdata1 [`DBG_NUM_TRIGGERS];  // Trigger config to both matchers
  csr_data_t tdata2 [`DBG_NUM_TRIGGERS];  // Compare values
  trig_vec_t if_match;
  trig_vec_t lsu_match;
  trig_vec_t hit_set;                     // Merge back to bank

  trig_csr_bank u_trig_csr_bank (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .apb_req_i (apb_req_i),
    .hit_set_i (hit_set),
    .apb_rsp_o (apb_rsp_o),
    .tdata1_o  (tdata1),
    .tdata2_o  (tdata2)
  );

  trig_exec_match u_trig_exec_match (
    .if_req_i     (if_req_i),
    .debug_mode_i (debug_mode_i),
    .tdata1_i     (tdata1),
    .tdata2_i     (tdata2),
    .match_o      (if_match)
  );

  trig_lsu_match u_trig_lsu_match (
    .lsu_req_i    (lsu_req_i),
    .debug_mode_i (debug_mode_i),
    .tdata1_i     (tdata1),
    .tdata2_i     (tdata2),
    .match_o      (lsu_match)
  );

  trig_hit_merge u_trig_hit_merge (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .if_match_i      (if_match),
    .lsu_match_i     (lsu_match),
    .debug_entry_i   (debug_entry_i),
    .trig_match_if_o (trig_match_if_o),
    .trig_match_ex_o (trig_match_ex_o),
    .debug_req_o     (debug_req_o),
    .hit_set_o       (hit_set)
  );

endmodule

// ==== hdl/trig_hit_merge.sv ====
//////////////////////////////////////////////////
// Registers raw matches, raises debug request, tracks hits for hit0
//////////////////////////////////////////////////
`timescale 1ns/1ps

module trig_hit_merge (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  trig_core_pkg::trig_vec_t if_match_i,       // Raw IF match
  input  trig_core_pkg::trig_vec_t lsu_match_i,      // Raw EX match
  input  logic                     debug_entry_i,    // Core enters debug mode
  output trig_core_pkg::trig_vec_t trig_match_if_o,
  output trig_core_pkg::trig_vec_t trig_match_ex_o,
  output logic                     debug_req_o,
  output trig_core_pkg::trig_vec_t hit_set_o         // One cycle pulse to the bank
);
  import trig_core_pkg::*;

  trig_vec_t match_if_q;
  trig_vec_t match_ex_q;
  trig_vec_t pending_q;   // Hits since last debug entry
  trig_vec_t pending_all; // Including the hits shown this cycle
  trig_vec_t hit_set_q;

  assign pending_all = pending_q | match_if_q | match_ex_q;

  //////////////////////////////////////////////////
  // Match registers and hit tracking
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      match_if_q <= '0;
      match_ex_q <= '0;
      pending_q  <= '0;
      hit_set_q  <= '0;
    end else begin
      match_if_q <= if_match_i;
      match_ex_q <= lsu_match_i;
      if (debug_entry_i) begin
        hit_set_q <= pending_all;  // Hand over, then start fresh
        pending_q <= '0;
      end else begin
        hit_set_q <= '0;
        pending_q <= pending_all;
      end
    end
  end

  assign trig_match_if_o = match_if_q;
  assign trig_match_ex_o = match_ex_q;
  assign debug_req_o     = |(match_if_q | match_ex_q);
  assign hit_set_o       = hit_set_q;

  // hit0 updates only follow a debug entry
  a_hit_after_entry : assert property (@(posedge clk) disable iff (!rst_n_i)
    (|hit_set_o) |-> $past(debug_entry_i));

endmodule

// ==== hdl/trig_lsu_match.sv ====
//////////////////////////////////////////////////
// Load/store address match in EX, combinational
// Byte enables give the lowest and highest bytes touched
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "trig_consts.svh"

module trig_lsu_match (
  input  trig_core_pkg::lsu_req_t  lsu_req_i,
  input  logic                     debug_mode_i,
  input  trig_csr_pkg::tdata1_t    tdata1_i [`DBG_NUM_TRIGGERS],
  input  trig_csr_pkg::csr_data_t  tdata2_i [`DBG_NUM_TRIGGERS],
  output trig_core_pkg::trig_vec_t match_o
);
  import trig_csr_pkg::*;
  import trig_core_pkg::*;

  logic [1:0] lo_idx;    // Lowest enabled byte
  logic [1:0] hi_idx;    // Highest enabled byte
  addr_t      addr_lo;
  addr_t      addr_hi;
  byte_en_t   be;

  assign be = lsu_req_i.be;

  // Scan upward for the top byte, downward for the bottom byte
  always_comb begin
    lo_idx = 2'd0;
    hi_idx = 2'd0;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) hi_idx = 2'(b);
    end
    for (int b = 3; b >= 0; b--) begin
      if (be[b]) lo_idx = 2'(b);
    end
  end

  assign addr_lo = {lsu_req_i.addr[31:2], lo_idx};
  assign addr_hi = {lsu_req_i.addr[31:2], hi_idx};

  for (genvar i = 0; i < `DBG_NUM_TRIGGERS; i++) begin : g_trig
    logic priv_en;
    logic dir_en;     // Load or store enable fits the access
    logic addr_hit;

    assign priv_en = (tdata1_i[i].m && (lsu_req_i.priv == PRIV_LVL_M)) ||
                     (tdata1_i[i].u && (lsu_req_i.priv == PRIV_LVL_U));
    assign dir_en  = (tdata1_i[i].load && !lsu_req_i.we) ||
                     (tdata1_i[i].store && lsu_req_i.we);

    always_comb begin
      case (tdata1_i[i].match)
        MATCH_GE: addr_hit = (addr_hi >= tdata2_i[i]);  // Some byte at or above
        MATCH_LT: addr_hit = (addr_lo < tdata2_i[i]);   // Some byte below
        default:  addr_hit = (lsu_req_i.addr[31:2] == tdata2_i[i][31:2]) &&
                             be[tdata2_i[i][1:0]];      // Same word, byte touched
      endcase
    end

    assign match_o[i] = lsu_req_i.valid &&
                        (tdata1_i[i].ttype == TTYPE_MCONTROL6) &&
                        priv_en && dir_en &&
                        !debug_mode_i &&
                        addr_hit;
  end

  // A valid access always touches at least one byte
  always_comb begin
    a_be_nonzero : assert final (!lsu_req_i.valid || (be != '0));
  end

endmodule

// ==== hdl/trig_exec_match.sv ====
//////////////////////////////////////////////////
// Instruction address match on the IF stage PC, combinational
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "trig_consts.svh"

module trig_exec_match (
  input  trig_core_pkg::if_req_t   if_req_i,
  input  logic                     debug_mode_i,  // No matching in debug mode
  input  trig_csr_pkg::tdata1_t    tdata1_i [`DBG_NUM_TRIGGERS],
  input  trig_csr_pkg::csr_data_t  tdata2_i [`DBG_NUM_TRIGGERS],
  output trig_core_pkg::trig_vec_t match_o
);
  import trig_csr_pkg::*;
  import trig_core_pkg::*;

  for (genvar i = 0; i < `DBG_NUM_TRIGGERS; i++) begin : g_trig
    logic priv_en;   // Enabled for the fetch privilege
    logic addr_hit;

    assign priv_en = (tdata1_i[i].m && (if_req_i.priv == PRIV_LVL_M)) ||
                     (tdata1_i[i].u && (if_req_i.priv == PRIV_LVL_U));

    // Compare the PC against tdata2
    always_comb begin
      case (tdata1_i[i].match)
        MATCH_GE: addr_hit = (if_req_i.pc >= tdata2_i[i]);
        MATCH_LT: addr_hit = (if_req_i.pc < tdata2_i[i]);
        default:  addr_hit = (if_req_i.pc == tdata2_i[i]);
      endcase
    end

    assign match_o[i] = if_req_i.valid &&
                        (tdata1_i[i].ttype == TTYPE_MCONTROL6) &&
                        tdata1_i[i].execute &&
                        priv_en &&
                        !debug_mode_i &&
                        addr_hit;
  end

endmodule

// ==== hdl/trig_csr_bank.sv ====
//////////////////////////////////////////////////
// APB register bank for tselect, tdata1, tdata2 and tinfo
// Resolves WARL fields on write and sets hit0 from the merge stage
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "trig_consts.svh"

module trig_csr_bank (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  trig_csr_pkg::apb_req_t   apb_req_i,
  input  trig_core_pkg::trig_vec_t hit_set_i,   // One cycle hit0 set request
  output trig_csr_pkg::apb_rsp_t   apb_rsp_o,
  output trig_csr_pkg::tdata1_t    tdata1_o [`DBG_NUM_TRIGGERS],
  output trig_csr_pkg::csr_data_t  tdata2_o [`DBG_NUM_TRIGGERS]
);
  import trig_csr_pkg::*;

  csr_data_t tselect_q;
  tdata1_t   tdata1_q [`DBG_NUM_TRIGGERS];
  tdata1_t   tdata1_n [`DBG_NUM_TRIGGERS];
  csr_data_t tdata2_q [`DBG_NUM_TRIGGERS];

  logic      access;       // APB access phase
  logic      wr_en;
  logic      addr_ok;      // Offset is in the map
  csr_data_t rdata;
  tdata1_t   sel_tdata1;   // Registers of the selected trigger
  csr_data_t sel_tdata2;
  tdata1_t   tdata1_wr;    // WARL resolved write data

  // Legalize a tdata1 write
  function automatic tdata1_t resolve_tdata1(input csr_data_t wdata);
    tdata1_t raw;
    tdata1_t res;
    raw = tdata1_t'(wdata);
    res = '0;
    if (raw.ttype == TTYPE_MCONTROL6) begin
      res.ttype   = TTYPE_MCONTROL6;
      res.dmode   = 1'b1;     // Debug mode access only
      res.action  = 4'd1;     // Enter debug on match
      res.hit0    = raw.hit0;
      res.m       = raw.m;
      res.u       = raw.u;
      res.execute = raw.execute;
      res.store   = raw.store;
      res.load    = raw.load;
      if ((raw.match == MATCH_GE) || (raw.match == MATCH_LT)) begin
        res.match = raw.match;
      end else begin
        res.match = MATCH_EQ;  // Unsupported modes fall back to equal
      end
    end else begin
      res = tdata1_t'(`TDATA1_RST_VAL);
    end
    return res;
  endfunction

  assign access    = apb_req_i.psel && apb_req_i.penable;
  assign wr_en     = access && apb_req_i.pwrite && addr_ok;
  assign tdata1_wr = resolve_tdata1(apb_req_i.pwdata);

  //////////////////////////////////////////////////
  // Read path and decode
  always_comb begin
    sel_tdata1 = tdata1_q[0];
    sel_tdata2 = tdata2_q[0];
    for (int i = 0; i < `DBG_NUM_TRIGGERS; i++) begin
      if (tselect_q == i) begin
        sel_tdata1 = tdata1_q[i];
        sel_tdata2 = tdata2_q[i];
      end
    end
    addr_ok = 1'b1;
    rdata   = '0;
    case (apb_req_i.paddr)
      `TRIG_ADDR_TSELECT: rdata = tselect_q;
      `TRIG_ADDR_TDATA1:  rdata = sel_tdata1;
      `TRIG_ADDR_TDATA2:  rdata = sel_tdata2;
      `TRIG_ADDR_TINFO:   rdata = `TINFO_VAL;
      default:            addr_ok = 1'b0;  // Hole in the map
    endcase
  end

  assign apb_rsp_o.prdata  = (access && !apb_req_i.pwrite) ? rdata : '0;
  assign apb_rsp_o.pready  = 1'b1;                // No wait states
  assign apb_rsp_o.pslverr = access && !addr_ok;

  //////////////////////////////////////////////////
  // tdata1 next value per trigger
  always_comb begin
    for (int i = 0; i < `DBG_NUM_TRIGGERS; i++) begin
      tdata1_n[i] = tdata1_q[i];
      // Hit update from debug entry wins over a register write
      if (hit_set_i[i] && (tdata1_q[i].ttype == TTYPE_MCONTROL6)) begin
        tdata1_n[i].hit0 = 1'b1;
      end else if (wr_en && (apb_req_i.paddr == `TRIG_ADDR_TDATA1) && (tselect_q == i)) begin
        tdata1_n[i] = tdata1_wr;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      tselect_q <= '0;
      for (int i = 0; i < `DBG_NUM_TRIGGERS; i++) begin
        tdata1_q[i] <= tdata1_t'(`TDATA1_RST_VAL);
        tdata2_q[i] <= '0;
      end
    end else begin
      // Out of range selects are dropped
      if (wr_en && (apb_req_i.paddr == `TRIG_ADDR_TSELECT) &&
          (apb_req_i.pwdata < `DBG_NUM_TRIGGERS)) begin
        tselect_q <= apb_req_i.pwdata;
      end
      for (int i = 0; i < `DBG_NUM_TRIGGERS; i++) begin
        tdata1_q[i] <= tdata1_n[i];
        if (wr_en && (apb_req_i.paddr == `TRIG_ADDR_TDATA2) && (tselect_q == i)) begin
          tdata2_q[i] <= apb_req_i.pwdata;  // Any compare value is legal
        end
      end
    end
  end

  assign tdata1_o = tdata1_q;
  assign tdata2_o = tdata2_q;

  // Access phase must come after setup
  a_apb_setup : assert property (@(posedge clk) disable iff (!rst_n_i)
    apb_req_i.penable |-> $past(apb_req_i.psel));

  // Select never leaves the implemented range
  a_tselect_range : assert property (@(posedge clk) disable iff (!rst_n_i)
    tselect_q < `DBG_NUM_TRIGGERS);

endmodule

// ==== hdl/trig_core_pkg.sv ====
//////////////////////////////////////////////////
// Core-side types of the trigger unit: privilege and pipeline requests
//////////////////////////////////////////////////
`include "trig_consts.svh"

package trig_core_pkg;

  // Privilege levels seen by the triggers
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_M = 2'd3
  } privlvl_e;

  typedef logic [31:0] addr_t;     // Byte address
  typedef logic [3:0]  byte_en_t;  // One bit per byte of a word

  // IF stage fetch, checked against execute triggers
  typedef struct packed {
    logic     valid;
    addr_t    pc;
    privlvl_e priv;
  } if_req_t;

  // EX stage load/store
  typedef struct packed {
    logic     valid;
    addr_t    addr;   // Word address in 31:2
    logic     we;     // High for store
    byte_en_t be;
    privlvl_e priv;
  } lsu_req_t;

  // One bit per trigger
  typedef logic [`DBG_NUM_TRIGGERS-1:0] trig_vec_t;

endpackage

// ==== hdl/trig_csr_pkg.sv ====
//////////////////////////////////////////////////
// Register-side types of the trigger unit: tdata1 layout and APB
//////////////////////////////////////////////////
package trig_csr_pkg;

  // tdata1.type encodings
  typedef enum logic [3:0] {
    TTYPE_MCONTROL6 = 4'd6,
    TTYPE_DISABLED  = 4'd15
  } ttype_e;

  // mcontrol6.match compare modes
  typedef enum logic [3:0] {
    MATCH_EQ = 4'd0,  // Equal
    MATCH_GE = 4'd2,  // Greater or equal, unsigned
    MATCH_LT = 4'd3   // Less than, unsigned
  } match_mode_e;

  typedef logic [31:0] csr_data_t;  // Register word
  typedef logic [3:0]  apb_addr_t;  // Byte offset in the register map

  // mcontrol6 view of tdata1, bit 31 first
  typedef struct packed {
    ttype_e      ttype;        // 31:28
    logic        dmode;        // 27
    logic        uncertain;    // 26
    logic        hit1;         // 25
    logic        vs;           // 24
    logic        vu;           // 23
    logic        hit0;         // 22
    logic        select;       // 21
    logic [1:0]  zero;         // 20:19
    logic [2:0]  size;         // 18:16
    logic [3:0]  action;       // 15:12
    logic        chain;        // 11
    match_mode_e match;        // 10:7
    logic        m;            // 6
    logic        uncertainen;  // 5
    logic        s;            // 4
    logic        u;            // 3
    logic        execute;      // 2
    logic        store;        // 1
    logic        load;         // 0
  } tdata1_t;

  // APB request from the debug host
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    csr_data_t pwdata;
  } apb_req_t;

  // APB response
  typedef struct packed {
    csr_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

endpackage

// ==== include/trig_consts.svh ====
//////////////////////////////////////////////////
// Trigger unit constants: count, APB map, reset values
// Included by packages and modules that size or decode
//////////////////////////////////////////////////
`ifndef TRIG_CONSTS_SVH
`define TRIG_CONSTS_SVH

// Number of implemented triggers
`define DBG_NUM_TRIGGERS 2

//////////////////////////////////////////////////
// APB register offsets
`define TRIG_ADDR_TSELECT 4'h0
`define TRIG_ADDR_TDATA1  4'h4
`define TRIG_ADDR_TDATA2  4'h8
`define TRIG_ADDR_TINFO   4'hC  // Read only

//////////////////////////////////////////////////
// Register values
`define TDATA1_RST_VAL 32'hF800_0000  // Disabled type, dmode set
`define TINFO_VAL      32'h0100_8040  // Types 6 and 15, version 1

`endif
